//--- hdl/be_defines.svh
`ifndef BE_DEFINES_SVH
`define BE_DEFINES_SVH

// data and pc width
`define BE_WORD_SIZE 32

// architectural and physical register counts
`define BE_NUM_ARCH_REG 8
`define BE_NUM_PHYS_REG 16

// instruction window sizes
`define BE_ROB_ENTRY 8
`define BE_ISSUE_ENTRY 4

`endif

//--- hdl/be_isa_pkg.sv
`default_nettype none
`include "be_defines.svh"

package be_isa_pkg;

  localparam int ARCH_IDX_W = $clog2(`BE_NUM_ARCH_REG);

  // alu codes first, the two branches last
  typedef enum logic [2:0]
  {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_ADDI = 3'd5,
    OP_BEQ  = 3'd6,
    OP_BNE  = 3'd7
  } be_op_e;

  // instruction as delivered by the front end
  typedef struct packed {
    be_op_e                   op;
    logic [ARCH_IDX_W-1:0]    rd;
    logic [ARCH_IDX_W-1:0]    rs1;
    logic [ARCH_IDX_W-1:0]    rs2;
    logic [15:0]              imm;
    logic [`BE_WORD_SIZE-1:0] pc;
    logic                     writes_rd;
  } decoded_instr_t;

endpackage

`default_nettype wire

//--- hdl/be_uarch_pkg.sv
`default_nettype none
`include "be_defines.svh"

package be_uarch_pkg;

  import be_isa_pkg::*;

  localparam int PHYS_IDX_W = $clog2(`BE_NUM_PHYS_REG);
  localparam int ROB_IDX_W  = $clog2(`BE_ROB_ENTRY);

  // rename to issue table
  typedef struct packed {
    be_op_e                   op;
    logic [15:0]              imm;
    logic [`BE_WORD_SIZE-1:0] pc;
    logic [PHYS_IDX_W-1:0]    pdest;
    logic [PHYS_IDX_W-1:0]    prs1;
    logic [PHYS_IDX_W-1:0]    prs2;
    logic                     writes_rd;
    logic [ROB_IDX_W-1:0]     rob_tag;
  } renamed_instr_t;

  // issue table to execute with operands already resolved
  typedef struct packed {
    be_op_e                   op;
    logic [15:0]              imm;
    logic [`BE_WORD_SIZE-1:0] pc;
    logic [ROB_IDX_W-1:0]     rob_tag;
    logic [PHYS_IDX_W-1:0]    pdest;
    logic                     writes_rd;
    logic [`BE_WORD_SIZE-1:0] rs1_val;
    logic [`BE_WORD_SIZE-1:0] rs2_val;
  } issued_instr_t;

  // result bus
  typedef struct packed {
    logic                     valid;
    logic [ROB_IDX_W-1:0]     rob_tag;
    logic [PHYS_IDX_W-1:0]    pdest;
    logic                     writes_rd;
    logic [`BE_WORD_SIZE-1:0] result;
    logic                     taken;
    logic [`BE_WORD_SIZE-1:0] target;
  } cdb_t;

  // rob entry written by rename with the pc kept for the retire port
  typedef struct packed {
    logic [ARCH_IDX_W-1:0]    rd;
    logic [PHYS_IDX_W-1:0]    pdest;
    logic [PHYS_IDX_W-1:0]    prev_pdest;
    logic                     writes_rd;
    logic [`BE_WORD_SIZE-1:0] pc;
  } rob_alloc_t;

endpackage

`default_nettype wire

//--- hdl/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "be_defines.svh"

module rename_stage
  import be_isa_pkg::*;
  import be_uarch_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire decoded_instr_t        decoded_i,
  input  wire logic                  decoded_v_i,
  output logic                       decode_ready_o,
  output renamed_instr_t             renamed_o,
  output logic                       renamed_v_o,
  input  wire logic                  issue_rename_ready_i,
  input  wire logic                  rob_ready_i,
  input  wire logic [ROB_IDX_W-1:0]  rob_num_i,
  output rob_alloc_t                 rename_rob_o,
  output logic                       rename_rob_v_o,
  input  wire logic                  commit_free_v_i,
  input  wire logic [PHYS_IDX_W-1:0] commit_free_reg_i,
  input  wire logic                  commit_map_v_i,
  input  wire logic [ARCH_IDX_W-1:0] commit_map_rd_i,
  input  wire logic [PHYS_IDX_W-1:0] commit_map_preg_i,
  input  wire logic                  mispredict_i
);

  localparam int NUM_ARCH = `BE_NUM_ARCH_REG;
  localparam int NUM_PHYS = `BE_NUM_PHYS_REG;
  // registers above the architectural ones start out free
  localparam logic [NUM_PHYS-1:0] INIT_FREE =
    {{(NUM_PHYS-NUM_ARCH){1'b1}}, {NUM_ARCH{1'b0}}};

  logic [PHYS_IDX_W-1:0] spec_map_q   [NUM_ARCH];
  logic [PHYS_IDX_W-1:0] commit_map_q [NUM_ARCH];
  logic [NUM_PHYS-1:0]   spec_free_q;
  logic [NUM_PHYS-1:0]   spec_free_d;
  logic [NUM_PHYS-1:0]   commit_free_q;
  logic [NUM_PHYS-1:0]   commit_free_d;
  logic [PHYS_IDX_W-1:0] alloc_preg;
  logic                  need_preg;
  logic                  fire;

  // lowest numbered free register
  always_comb
  begin
    alloc_preg = '0;
    for (int i = NUM_PHYS - 1; i >= 0; i--)
      if (spec_free_q[i])
        alloc_preg = PHYS_IDX_W'(i);
  end

  assign need_preg = decoded_i.writes_rd;

  assign decode_ready_o = !mispredict_i && rob_ready_i
                       && (!renamed_v_o || issue_rename_ready_i)
                       && (!need_preg || (|spec_free_q));
  assign fire = decoded_v_i && decode_ready_o;

  assign rename_rob_v_o = fire;

  always_comb
  begin
    rename_rob_o.rd         = decoded_i.rd;
    rename_rob_o.pdest      = need_preg ? alloc_preg : '0;
    rename_rob_o.prev_pdest = spec_map_q[decoded_i.rd];
    rename_rob_o.writes_rd  = need_preg;
    rename_rob_o.pc         = decoded_i.pc;
  end

  always_comb
  begin
    spec_free_d   = spec_free_q;
    commit_free_d = commit_free_q;
    if (fire && need_preg)
      spec_free_d[alloc_preg] = 1'b0;
    if (commit_free_v_i)
    begin
      spec_free_d[commit_free_reg_i]   = 1'b1;
      commit_free_d[commit_free_reg_i] = 1'b1;
    end
    // committed register is no longer free in the committed view
    if (commit_map_v_i)
      commit_free_d[commit_map_preg_i] = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < NUM_ARCH; i++)
      begin
        spec_map_q[i]   <= PHYS_IDX_W'(i);
        commit_map_q[i] <= PHYS_IDX_W'(i);
      end
      spec_free_q   <= INIT_FREE;
      commit_free_q <= INIT_FREE;
      renamed_v_o   <= 1'b0;
    end
    else
    begin
      commit_free_q <= commit_free_d;
      if (commit_map_v_i)
        commit_map_q[commit_map_rd_i] <= commit_map_preg_i;
      if (mispredict_i)
      begin
        // fall back to the retired state
        spec_map_q  <= commit_map_q;
        spec_free_q <= commit_free_q;
        renamed_v_o <= 1'b0;
      end
      else
      begin
        spec_free_q <= spec_free_d;
        if (fire && need_preg)
          spec_map_q[decoded_i.rd] <= alloc_preg;
        if (fire)
          renamed_v_o <= 1'b1;
        else if (issue_rename_ready_i)
          renamed_v_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fire)
    begin
      renamed_o.op        <= decoded_i.op;
      renamed_o.imm       <= decoded_i.imm;
      renamed_o.pc        <= decoded_i.pc;
      renamed_o.pdest     <= rename_rob_o.pdest;
      renamed_o.prs1      <= spec_map_q[decoded_i.rs1];
      renamed_o.prs2      <= spec_map_q[decoded_i.rs2];
      renamed_o.writes_rd <= need_preg;
      renamed_o.rob_tag   <= rob_num_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/issue_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "be_defines.svh"

module issue_table
  import be_uarch_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  input  wire renamed_instr_t           instruction_i,
  input  wire logic                     valid_i,
  output logic                          ready_o,
  output logic [PHYS_IDX_W-1:0]         rs1_addr_o,
  output logic [PHYS_IDX_W-1:0]         rs2_addr_o,
  input  wire logic                     rs1_valid_i,
  input  wire logic                     rs2_valid_i,
  input  wire logic [`BE_WORD_SIZE-1:0] rs1_data_i,
  input  wire logic [`BE_WORD_SIZE-1:0] rs2_data_i,
  input  wire cdb_t                     cdb_i,
  output issued_instr_t                 instruction_o,
  output logic                          valid_o,
  input  wire logic                     mispredict_i
);

  localparam int N     = `BE_ISSUE_ENTRY;
  localparam int IDX_W = $clog2(N);

  typedef struct packed {
    renamed_instr_t           instr;
    logic                     rdy1;
    logic                     rdy2;
    logic [`BE_WORD_SIZE-1:0] val1;
    logic [`BE_WORD_SIZE-1:0] val2;
  } entry_t;

  // entries stay packed toward slot 0, so lower slots are older
  logic [N-1:0]     valid_q;
  logic [N-1:0]     valid_d;
  entry_t           ent_q [N];
  entry_t           ent_d [N];
  entry_t           woken [N];
  entry_t           new_ent;
  logic [N-1:0]     can_issue;
  logic [IDX_W-1:0] sel;
  logic [IDX_W:0]   count;
  logic             fire;

  assign ready_o    = !(&valid_q);
  assign fire       = valid_i && ready_o;
  assign rs1_addr_o = instruction_i.prs1;
  assign rs2_addr_o = instruction_i.prs2;

  // operand capture at insertion where the result bus wins over the register file
  always_comb
  begin
    new_ent.instr = instruction_i;
    new_ent.rdy1  = rs1_valid_i;
    new_ent.val1  = rs1_data_i;
    new_ent.rdy2  = rs2_valid_i;
    new_ent.val2  = rs2_data_i;
    if (cdb_i.valid && cdb_i.writes_rd && (cdb_i.pdest == instruction_i.prs1))
    begin
      new_ent.rdy1 = 1'b1;
      new_ent.val1 = cdb_i.result;
    end
    if (cdb_i.valid && cdb_i.writes_rd && (cdb_i.pdest == instruction_i.prs2))
    begin
      new_ent.rdy2 = 1'b1;
      new_ent.val2 = cdb_i.result;
    end
  end

  // wakeup of waiting entries
  always_comb
  begin
    for (int i = 0; i < N; i++)
    begin
      woken[i] = ent_q[i];
      if (cdb_i.valid && cdb_i.writes_rd && !ent_q[i].rdy1
          && (cdb_i.pdest == ent_q[i].instr.prs1))
      begin
        woken[i].rdy1 = 1'b1;
        woken[i].val1 = cdb_i.result;
      end
      if (cdb_i.valid && cdb_i.writes_rd && !ent_q[i].rdy2
          && (cdb_i.pdest == ent_q[i].instr.prs2))
      begin
        woken[i].rdy2 = 1'b1;
        woken[i].val2 = cdb_i.result;
      end
      can_issue[i] = valid_q[i] && ent_q[i].rdy1 && ent_q[i].rdy2;
    end
  end

  // oldest ready entry
  always_comb
  begin
    sel = '0;
    for (int i = N - 1; i >= 0; i--)
      if (can_issue[i])
        sel = IDX_W'(i);
  end

  assign valid_o = |can_issue;

  always_comb
  begin
    instruction_o.op        = ent_q[sel].instr.op;
    instruction_o.imm       = ent_q[sel].instr.imm;
    instruction_o.pc        = ent_q[sel].instr.pc;
    instruction_o.rob_tag   = ent_q[sel].instr.rob_tag;
    instruction_o.pdest     = ent_q[sel].instr.pdest;
    instruction_o.writes_rd = ent_q[sel].instr.writes_rd;
    instruction_o.rs1_val   = ent_q[sel].val1;
    instruction_o.rs2_val   = ent_q[sel].val2;
  end

  // close the gap left by the issued entry, then append the new one
  always_comb
  begin
    int src;
    count = '0;
    for (int i = 0; i < N; i++)
      count = count + (IDX_W+1)'(valid_q[i]);
    if (valid_o)
      count = count - 1'b1;
    valid_d = '0;
    for (int i = 0; i < N; i++)
    begin
      ent_d[i] = woken[i];
      src      = (valid_o && (i >= int'(sel))) ? i + 1 : i;
      if (src < N)
      begin
        valid_d[i] = valid_q[src];
        ent_d[i]   = woken[src];
      end
    end
    if (fire)
    begin
      valid_d[count[IDX_W-1:0]] = 1'b1;
      ent_d[count[IDX_W-1:0]]   = new_ent;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      valid_q <= '0;
    else if (mispredict_i)
      valid_q <= '0;
    else
      valid_q <= valid_d;
  end

  always_ff @(posedge clk_i)
  begin
    ent_q <= ent_d;
  end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "be_defines.svh"

module execute_stage
  import be_isa_pkg::*;
  import be_uarch_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  wire logic          issue_exe_v_i,
  input  wire issued_instr_t issue_exe_i,
  input  wire logic          mispredict_i,
  output cdb_t               cdb_o
);

  logic [`BE_WORD_SIZE-1:0] imm_ext;
  logic [`BE_WORD_SIZE-1:0] op_b;
  logic [`BE_WORD_SIZE-1:0] alu_res;
  logic                     taken;
  cdb_t                     cdb_d;
  cdb_t                     cdb_q;

  assign imm_ext = {{(`BE_WORD_SIZE-16){issue_exe_i.imm[15]}}, issue_exe_i.imm};
  // addi swaps rs2 for the immediate
  assign op_b = (issue_exe_i.op == OP_ADDI) ? imm_ext : issue_exe_i.rs2_val;

  always_comb
  begin
    case (issue_exe_i.op)
      OP_SUB:  alu_res = issue_exe_i.rs1_val - op_b;
      OP_AND:  alu_res = issue_exe_i.rs1_val & op_b;
      OP_OR:   alu_res = issue_exe_i.rs1_val | op_b;
      OP_XOR:  alu_res = issue_exe_i.rs1_val ^ op_b;
      default: alu_res = issue_exe_i.rs1_val + op_b;
    endcase
  end

  // predicted not-taken, so taken means redirect
  assign taken = ((issue_exe_i.op == OP_BEQ) && (issue_exe_i.rs1_val == issue_exe_i.rs2_val))
              || ((issue_exe_i.op == OP_BNE) && (issue_exe_i.rs1_val != issue_exe_i.rs2_val));

  always_comb
  begin
    // a result issued under a mispredict is dropped
    cdb_d.valid     = issue_exe_v_i && !mispredict_i;
    cdb_d.rob_tag   = issue_exe_i.rob_tag;
    cdb_d.pdest     = issue_exe_i.pdest;
    cdb_d.writes_rd = issue_exe_i.writes_rd;
    cdb_d.result    = alu_res;
    cdb_d.taken     = taken;
    cdb_d.target    = issue_exe_i.pc + imm_ext;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cdb_q <= '0;
    else
      cdb_q <= cdb_d;
  end

  assign cdb_o = cdb_q;

endmodule

`default_nettype wire

//--- hdl/commit_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "be_defines.svh"

module commit_stage
  import be_isa_pkg::*;
  import be_uarch_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  rename_rob_v_i,
  input  wire rob_alloc_t            rename_rob_i,
  output logic                       rob_ready_o,
  output logic [ROB_IDX_W-1:0]       rob_num_o,
  input  wire cdb_t                  cdb_i,
  input  wire logic [PHYS_IDX_W-1:0] rs1_addr_i,
  input  wire logic [PHYS_IDX_W-1:0] rs2_addr_i,
  output logic                       rs1_valid_o,
  output logic                       rs2_valid_o,
  output logic [`BE_WORD_SIZE-1:0]   rs1_data_o,
  output logic [`BE_WORD_SIZE-1:0]   rs2_data_o,
  output logic                       free_v_o,
  output logic [PHYS_IDX_W-1:0]      free_reg_o,
  output logic                       map_v_o,
  output logic [ARCH_IDX_W-1:0]      map_rd_o,
  output logic [PHYS_IDX_W-1:0]      map_preg_o,
  output logic                       mispredict_o,
  output logic [`BE_WORD_SIZE-1:0]   redirected_pc_o,
  output logic                       commit_v_o,
  output logic [ARCH_IDX_W-1:0]      commit_rd_o,
  output logic                       commit_writes_o,
  output logic [`BE_WORD_SIZE-1:0]   commit_data_o,
  output logic [`BE_WORD_SIZE-1:0]   commit_pc_o
);

  localparam int DEPTH    = `BE_ROB_ENTRY;
  localparam int NUM_PHYS = `BE_NUM_PHYS_REG;

  rob_alloc_t               rob_q    [DEPTH];
  logic [`BE_WORD_SIZE-1:0] target_q [DEPTH];
  logic [DEPTH-1:0]         done_q;
  logic [DEPTH-1:0]         taken_q;
  // extra msb tells full from empty
  logic [ROB_IDX_W:0]       head_q;
  logic [ROB_IDX_W:0]       tail_q;
  logic [ROB_IDX_W-1:0]     head;
  logic                     rob_empty;
  logic [`BE_WORD_SIZE-1:0] prf_q [NUM_PHYS];
  logic [NUM_PHYS-1:0]      prf_rdy_q;

  assign head        = head_q[ROB_IDX_W-1:0];
  assign rob_num_o   = tail_q[ROB_IDX_W-1:0];
  assign rob_empty   = (head_q == tail_q);
  assign rob_ready_o = !((head_q[ROB_IDX_W] != tail_q[ROB_IDX_W]) && (head == rob_num_o));

  // register file read for the issue table
  assign rs1_valid_o = prf_rdy_q[rs1_addr_i];
  assign rs2_valid_o = prf_rdy_q[rs2_addr_i];
  assign rs1_data_o  = prf_q[rs1_addr_i];
  assign rs2_data_o  = prf_q[rs2_addr_i];

  // head retires once its result has been written back
  assign commit_v_o      = !rob_empty && done_q[head];
  assign commit_rd_o     = rob_q[head].rd;
  assign commit_writes_o = rob_q[head].writes_rd;
  assign commit_data_o   = prf_q[rob_q[head].pdest];
  assign commit_pc_o     = rob_q[head].pc;

  assign mispredict_o    = commit_v_o && taken_q[head];
  assign redirected_pc_o = target_q[head];

  assign free_v_o   = commit_v_o && rob_q[head].writes_rd;
  assign free_reg_o = rob_q[head].prev_pdest;
  assign map_v_o    = free_v_o;
  assign map_rd_o   = rob_q[head].rd;
  assign map_preg_o = rob_q[head].pdest;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      head_q <= '0;
      tail_q <= '0;
      done_q <= '0;
    end
    else if (mispredict_o)
    begin
      // everything behind the branch is wrong path
      head_q <= '0;
      tail_q <= '0;
      done_q <= '0;
    end
    else
    begin
      if (commit_v_o)
        head_q <= head_q + 1'b1;
      if (rename_rob_v_i)
      begin
        tail_q            <= tail_q + 1'b1;
        done_q[rob_num_o] <= 1'b0;
      end
      if (cdb_i.valid)
        done_q[cdb_i.rob_tag] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rename_rob_v_i)
      rob_q[rob_num_o] <= rename_rob_i;
    if (cdb_i.valid)
    begin
      taken_q[cdb_i.rob_tag]  <= cdb_i.taken;
      target_q[cdb_i.rob_tag] <= cdb_i.target;
    end
  end

  // physical registers come up zero and ready
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < NUM_PHYS; i++)
        prf_q[i] <= '0;
      prf_rdy_q <= '1;
    end
    else
    begin
      if (cdb_i.valid && cdb_i.writes_rd)
      begin
        prf_q[cdb_i.pdest]     <= cdb_i.result;
        prf_rdy_q[cdb_i.pdest] <= 1'b1;
      end
      if (rename_rob_v_i && rename_rob_i.writes_rd)
        prf_rdy_q[rename_rob_i.pdest] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/be_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "be_defines.svh"

module be_top
  import be_isa_pkg::*;
  import be_uarch_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  // front end to rename
  input  wire decoded_instr_t        decoded_i,
  input  wire logic                  decoded_v_i,
  output logic                       rename_decode_ready_o,
  // redirect back to the front end
  output logic                       be_fe_mispredict_o,
  output logic [`BE_WORD_SIZE-1:0]   be_fe_redirected_pc_o,
  // retire port
  output logic                       commit_v_o,
  output logic [ARCH_IDX_W-1:0]      commit_rd_o,
  output logic                       commit_writes_o,
  output logic [`BE_WORD_SIZE-1:0]   commit_data_o,
  output logic [`BE_WORD_SIZE-1:0]   commit_pc_o
);

  // rename <-> issue
  renamed_instr_t           rename_issue_entry;
  logic                     rename_issue_v;
  logic                     issue_rename_ready;

  // rename <-> rob
  rob_alloc_t               rename_rob_entry;
  logic                     rename_rob_v;
  logic                     rob_ready;
  logic [ROB_IDX_W-1:0]     rob_rename_num;

  // commit back to rename
  logic                     commit_free_v;
  logic [PHYS_IDX_W-1:0]    commit_free_reg;
  logic                     commit_map_v;
  logic [ARCH_IDX_W-1:0]    commit_map_rd;
  logic [PHYS_IDX_W-1:0]    commit_map_preg;

  // issue reads the register file
  logic [PHYS_IDX_W-1:0]    issue_rs1;
  logic [PHYS_IDX_W-1:0]    issue_rs2;
  logic                     rs1_valid;
  logic                     rs2_valid;
  logic [`BE_WORD_SIZE-1:0] rs1_data;
  logic [`BE_WORD_SIZE-1:0] rs2_data;

  // issue -> execute, and the result bus
  issued_instr_t            issue_exe_entry;
  logic                     issue_exe_v;
  cdb_t                     cdb;

  rename_stage rename
  (  .clk_i                (clk_i)
   , .rst_n_i              (rst_n_i)
   , .decoded_i            (decoded_i)
   , .decoded_v_i          (decoded_v_i)
   , .decode_ready_o       (rename_decode_ready_o)
   , .renamed_o            (rename_issue_entry)
   , .renamed_v_o          (rename_issue_v)
   , .issue_rename_ready_i (issue_rename_ready)
   , .rob_ready_i          (rob_ready)
   , .rob_num_i            (rob_rename_num)
   , .rename_rob_o         (rename_rob_entry)
   , .rename_rob_v_o       (rename_rob_v)
   , .commit_free_v_i      (commit_free_v)
   , .commit_free_reg_i    (commit_free_reg)
   , .commit_map_v_i       (commit_map_v)
   , .commit_map_rd_i      (commit_map_rd)
   , .commit_map_preg_i    (commit_map_preg)
   , .mispredict_i         (be_fe_mispredict_o)
  );

  issue_table issue
  (  .clk_i         (clk_i)
   , .rst_n_i       (rst_n_i)
   , .instruction_i (rename_issue_entry)
   , .valid_i       (rename_issue_v)
   , .ready_o       (issue_rename_ready)
   , .rs1_addr_o    (issue_rs1)
   , .rs2_addr_o    (issue_rs2)
   , .rs1_valid_i   (rs1_valid)
   , .rs2_valid_i   (rs2_valid)
   , .rs1_data_i    (rs1_data)
   , .rs2_data_i    (rs2_data)
   , .cdb_i         (cdb)
   , .instruction_o (issue_exe_entry)
   , .valid_o       (issue_exe_v)
   , .mispredict_i  (be_fe_mispredict_o)
  );

  execute_stage execute
  (  .clk_i         (clk_i)
   , .rst_n_i       (rst_n_i)
   , .issue_exe_v_i (issue_exe_v)
   , .issue_exe_i   (issue_exe_entry)
   , .mispredict_i  (be_fe_mispredict_o)
   , .cdb_o         (cdb)
  );

  commit_stage commit
  (  .clk_i           (clk_i)
   , .rst_n_i         (rst_n_i)
   , .rename_rob_v_i  (rename_rob_v)
   , .rename_rob_i    (rename_rob_entry)
   , .rob_ready_o     (rob_ready)
   , .rob_num_o       (rob_rename_num)
   , .cdb_i           (cdb)
   , .rs1_addr_i      (issue_rs1)
   , .rs2_addr_i      (issue_rs2)
   , .rs1_valid_o     (rs1_valid)
   , .rs2_valid_o     (rs2_valid)
   , .rs1_data_o      (rs1_data)
   , .rs2_data_o      (rs2_data)
   , .free_v_o        (commit_free_v)
   , .free_reg_o      (commit_free_reg)
   , .map_v_o         (commit_map_v)
   , .map_rd_o        (commit_map_rd)
   , .map_preg_o      (commit_map_preg)
   , .mispredict_o    (be_fe_mispredict_o)
   , .redirected_pc_o (be_fe_redirected_pc_o)
   , .commit_v_o      (commit_v_o)
   , .commit_rd_o     (commit_rd_o)
   , .commit_writes_o (commit_writes_o)
   , .commit_data_o   (commit_data_o)
   , .commit_pc_o     (commit_pc_o)
  );

endmodule

`default_nettype wire

//--- test/tb_be_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "be_defines.svh"

module tb_be_top
  import be_isa_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam int STREAM  = 3 * `BE_ROB_ENTRY;

  // one expected retire in program order
  typedef struct packed {
    logic [2:0]               rd;
    logic                     writes;
    logic [`BE_WORD_SIZE-1:0] data;
    logic [`BE_WORD_SIZE-1:0] pc;
    logic                     taken;
    logic [`BE_WORD_SIZE-1:0] target;
  } retire_t;

  logic                     clk_i;
  logic                     rst_n_i;
  decoded_instr_t           decoded_i;
  logic                     decoded_v_i;
  logic                     rename_decode_ready_o;
  logic                     be_fe_mispredict_o;
  logic [`BE_WORD_SIZE-1:0] be_fe_redirected_pc_o;
  logic                     commit_v_o;
  logic [2:0]               commit_rd_o;
  logic                     commit_writes_o;
  logic [`BE_WORD_SIZE-1:0] commit_data_o;
  logic [`BE_WORD_SIZE-1:0] commit_pc_o;

  // reference model state
  logic [`BE_WORD_SIZE-1:0] arch_q [8];
  retire_t                  exp_q [$];
  logic [31:0]              lfsr_q;
  logic [`BE_WORD_SIZE-1:0] next_pc;
  // set while instructions behind a taken branch are wrong path
  logic                     squash;
  int                       squash_mark;
  int                       stalls;
  int                       mispredicts = 0;

  be_top dut
  (  .clk_i                 (clk_i)
   , .rst_n_i               (rst_n_i)
   , .decoded_i             (decoded_i)
   , .decoded_v_i           (decoded_v_i)
   , .rename_decode_ready_o (rename_decode_ready_o)
   , .be_fe_mispredict_o    (be_fe_mispredict_o)
   , .be_fe_redirected_pc_o (be_fe_redirected_pc_o)
   , .commit_v_o            (commit_v_o)
   , .commit_rd_o           (commit_rd_o)
   , .commit_writes_o       (commit_writes_o)
   , .commit_data_o         (commit_data_o)
   , .commit_pc_o           (commit_pc_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else report_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [`BE_WORD_SIZE-1:0] sext16(input logic [15:0] imm);
    return {{(`BE_WORD_SIZE-16){imm[15]}}, imm};
  endfunction

  function automatic logic [`BE_WORD_SIZE-1:0] isa_result(input be_op_e op,
      input logic [`BE_WORD_SIZE-1:0] a, input logic [`BE_WORD_SIZE-1:0] b,
      input logic [15:0] imm);
    case (op)
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + sext16(imm);
      default: return a + b;
    endcase
  endfunction

  // program-order model applied on each accepted instruction
  task automatic model_accept(input decoded_instr_t ins);
    retire_t                  e;
    logic [`BE_WORD_SIZE-1:0] a;
    logic [`BE_WORD_SIZE-1:0] b;
    if (squash && (mispredicts != squash_mark))
      squash = 1'b0;
    if (squash)
      return;
    a        = arch_q[ins.rs1];
    b        = arch_q[ins.rs2];
    e.rd     = ins.rd;
    e.writes = ins.writes_rd;
    e.pc     = ins.pc;
    e.data   = isa_result(ins.op, a, b, ins.imm);
    e.taken  = ((ins.op == OP_BEQ) && (a == b)) || ((ins.op == OP_BNE) && (a != b));
    e.target = ins.pc + sext16(ins.imm);
    if (ins.writes_rd)
      arch_q[ins.rd] = e.data;
    exp_q.push_back(e);
    if (e.taken)
    begin
      squash      = 1'b1;
      squash_mark = mispredicts;
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send(input be_op_e op, input logic [2:0] rd, input logic [2:0] rs1,
                      input logic [2:0] rs2, input logic [15:0] imm);
    decoded_instr_t ins;
    logic           accepted;
    int             waited;
    ins.op        = op;
    ins.rd        = rd;
    ins.rs1       = rs1;
    ins.rs2       = rs2;
    ins.imm       = imm;
    ins.pc        = next_pc;
    ins.writes_rd = (op != OP_BEQ) && (op != OP_BNE);
    next_pc       = next_pc + 32'd4;
    decoded_i     = ins;
    decoded_v_i   = 1'b1;
    accepted      = 1'b0;
    waited        = 0;
    while (!accepted)
    begin
      // ready is settled well before the rising edge
      #1;
      accepted = rename_decode_ready_o;
      if (accepted)
        model_accept(ins);
      else
        stalls++;
      @(negedge clk_i);
      waited++;
      assert (waited < TIMEOUT)
      else report_error("front end handshake did not complete in time");
    end
    decoded_v_i = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    do
    begin
      @(posedge clk_i);
      waited++;
      assert (waited < TIMEOUT)
      else report_error("expected instructions did not retire in time");
    end
    while ((exp_q.size() != 0) || (squash && (mispredicts == squash_mark)));
    repeat (4) @(negedge clk_i);
  endtask

  // retire port checker
  always @(negedge clk_i)
  begin
    retire_t e;
    if (rst_n_i)
    begin
      assert (!be_fe_mispredict_o || commit_v_o)
      else report_error("mispredict raised without a retiring instruction");
      if (commit_v_o)
      begin
        assert (exp_q.size() != 0)
        else report_error($sformatf("unexpected retire of pc %h", commit_pc_o));
        e = exp_q.pop_front();
        check_value("commit_pc_o", commit_pc_o, e.pc);
        check_value("commit_writes_o", 32'(commit_writes_o), 32'(e.writes));
        if (e.writes)
        begin
          check_value("commit_rd_o", 32'(commit_rd_o), 32'(e.rd));
          check_value("commit_data_o", commit_data_o, e.data);
        end
        check_value("be_fe_mispredict_o", 32'(be_fe_mispredict_o), 32'(e.taken));
        if (e.taken)
          check_value("be_fe_redirected_pc_o", be_fe_redirected_pc_o, e.target);
        if (be_fe_mispredict_o)
          mispredicts++;
      end
    end
  end

  task automatic test_reset_state();
    check_value("be_fe_mispredict_o", 32'(be_fe_mispredict_o), 32'd0);
    check_value("commit_v_o", 32'(commit_v_o), 32'd0);
    check_value("rename_decode_ready_o", 32'(rename_decode_ready_o), 32'd1);
    send(OP_ADD, 3'd1, 3'd2, 3'd3, 16'd0);
    drain();
  endtask

  task automatic test_independent_ops();
    logic [31:0] k;
    logic [2:0]  rd;
    logic [2:0]  rs1;
    logic [2:0]  rs2;
    logic [15:0] imm;
    // give every register a nonzero start value
    for (int r = 0; r < 8; r++)
    begin
      imm = 16'(take_bits(16));
      send(OP_ADDI, 3'(r), 3'(r), 3'd0, imm);
    end
    for (int i = 0; i < 20; i++)
    begin
      k   = take_bits(3) % 6;
      rd  = 3'(take_bits(3));
      rs1 = 3'(take_bits(3));
      rs2 = 3'(take_bits(3));
      imm = 16'(take_bits(16));
      send(be_op_e'(k[2:0]), rd, rs1, rs2, imm);
    end
    drain();
  endtask

  task automatic test_dependency_chains();
    logic [15:0] imm;
    for (int round = 0; round < 3; round++)
    begin
      imm = 16'(take_bits(16));
      // reads the register it writes
      send(OP_ADDI, 3'd1, 3'd1, 3'd0, imm);
      repeat (round) @(negedge clk_i);
      send(OP_ADD, 3'd2, 3'd1, 3'd1, 16'd0);
      send(OP_SUB, 3'd3, 3'd2, 3'd1, 16'd0);
      repeat (round) @(negedge clk_i);
      send(OP_XOR, 3'd4, 3'd3, 3'd2, 16'd0);
      send(OP_AND, 3'd1, 3'd4, 3'd1, 16'd0);
      send(OP_OR, 3'd5, 3'd1, 3'd4, 16'd0);
      imm = 16'(take_bits(16));
      send(OP_ADDI, 3'd5, 3'd5, 3'd0, imm);
    end
    drain();
  endtask

  task automatic test_back_pressure();
    logic [15:0] imm;
    stalls = 0;
    // a serial chain issues at half rate, so the window fills up
    for (int i = 0; i < STREAM; i++)
    begin
      imm = 16'(take_bits(16));
      send(OP_ADDI, 3'd6, 3'd6, 3'd0, imm);
    end
    drain();
    assert (stalls > 0)
    else report_error("ready never dropped during the long stream");
  endtask

  task automatic test_taken_branch();
    logic [`BE_WORD_SIZE-1:0] br_pc;
    send(OP_ADDI, 3'd1, 3'd0, 3'd0, 16'h0011);
    drain();
    br_pc = next_pc;
    send(OP_BEQ, 3'd0, 3'd1, 3'd1, 16'h0040);
    // wrong path
    send(OP_ADDI, 3'd1, 3'd1, 3'd0, 16'h0005);
    send(OP_ADD, 3'd2, 3'd1, 3'd1, 16'd0);
    drain();
    next_pc = br_pc + 32'h40;
    send(OP_ADD, 3'd3, 3'd1, 3'd2, 16'd0);
    send(OP_ADDI, 3'd4, 3'd1, 3'd0, 16'hfff0);
    drain();
  endtask

  task automatic test_not_taken_branch();
    send(OP_XOR, 3'd1, 3'd1, 3'd1, 16'd0);
    send(OP_ADDI, 3'd2, 3'd1, 3'd0, 16'h0001);
    // 0 against 1, then a register against itself
    send(OP_BEQ, 3'd0, 3'd1, 3'd2, 16'h0020);
    send(OP_BNE, 3'd0, 3'd2, 3'd2, 16'hffe0);
    send(OP_ADD, 3'd3, 3'd1, 3'd2, 16'd0);
    send(OP_SUB, 3'd4, 3'd2, 3'd3, 16'd0);
    drain();
  endtask

  initial
  begin
    rst_n_i     = 1'b0;
    decoded_i   = '0;
    decoded_v_i = 1'b0;
    lfsr_q      = 32'd82684;
    next_pc     = 32'h0000_1000;
    squash      = 1'b0;
    squash_mark = 0;
    stalls      = 0;
    for (int i = 0; i < 8; i++)
      arch_q[i] = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    test_reset_state();
    test_independent_ops();
    test_dependency_chains();
    test_back_pressure();
    test_taken_branch();
    test_not_taken_branch();
    if (exp_q.size() == 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("%0d expected retires never happened", exp_q.size());
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/be_isa_pkg.sv
hdl/be_uarch_pkg.sv
hdl/rename_stage.sv
hdl/issue_table.sv
hdl/execute_stage.sv
hdl/commit_stage.sv
hdl/be_top.sv
test/tb_be_top.sv

//--- Makefile
SRCS := $(shell grep -v '^+' build.f) hdl/be_defines.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_be_top: build.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_be_top -f build.f -o Vtb_be_top

run: obj_dir/Vtb_be_top
	./obj_dir/Vtb_be_top | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
